/* hdl/exec_pkg.sv */
// Execute stage package with width constants, opcode and condition enums, stage bundles
package exec_pkg;

    localparam int XLEN    = 32;  // Data and address width
    localparam int CS_W    = 16;  // Code segment selector width
    localparam int FLAG_W  = 7;   // Flags modeled by this stage
    localparam int SHAMT_W = 5;   // Shift count bits taken from op2

    // Micro-op opcodes
    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_ADD   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_NOT   = 4'd4,
        OP_SAL   = 4'd5,
        OP_SAR   = 4'd6,
        OP_CMP   = 4'd7,
        OP_MOV   = 4'd8,
        OP_XCHG  = 4'd9,
        OP_CMOVC = 4'd10,
        OP_JMP   = 4'd11,  // Near jump, relative to next_eip
        OP_JMPF  = 4'd12,  // Far jump, absolute target plus selector
        OP_JCC   = 4'd13   // Conditional near jump
    } alu_op_e;

    // Condition codes for JCC
    typedef enum logic [2:0] {
        CC_ALWAYS = 3'd0,
        CC_C      = 3'd1,  // Carry set
        CC_NC     = 3'd2,  // Carry clear
        CC_Z      = 3'd3,  // Zero set
        CC_NZ     = 3'd4   // Zero clear
    } cond_e;

    // EFLAGS subset, fmask uses the same bit layout
    typedef struct packed {
        logic cf;
        logic pf;
        logic af;
        logic zf;
        logic sf;
        logic of;
        logic df;
    } flags_t;

    // One decoded micro-op from the front end
    typedef struct packed {
        logic            valid;
        alu_op_e         op;
        cond_e           cond;
        logic [XLEN-1:0] eip;
        logic [XLEN-1:0] next_eip;     // Fall-through address
        logic            pred_taken;   // Front end prediction
        logic [XLEN-1:0] pred_target;
        logic [XLEN-1:0] op1;
        logic [XLEN-1:0] op2;
        logic [XLEN-1:0] dest1;
        logic [XLEN-1:0] dest2;
        logic            ld1;          // Writeback requests
        logic            ld2;
    } uop_t;

    // ALU output bundle
    typedef struct packed {
        logic [XLEN-1:0]   res1;
        logic [XLEN-1:0]   res2;
        logic [XLEN-1:0]   dest1;
        logic [XLEN-1:0]   dest2;
        logic              wb1;
        logic              wb2;
        flags_t            flags;
        logic [FLAG_W-1:0] fmask;  // Flags written by this op
    } alu_res_t;

    // Branch resolution bundle
    typedef struct packed {
        logic            valid;
        logic            taken;
        logic            correct;   // Prediction matched
        logic [XLEN-1:0] fip;       // Next fetch address
        logic [CS_W-1:0] cs;        // Far jump only
        logic            cond_met;
    } br_res_t;

    // Registered result bundle
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] eip;
        logic [XLEN-1:0] res1;
        logic [XLEN-1:0] res2;
        logic [XLEN-1:0] dest1;
        logic [XLEN-1:0] dest2;
        logic            wb1;
        logic            wb2;
    } commit_t;

endpackage

/* hdl/exec_alu.sv */
// Integer ALU with results, destinations, flags and flag write mask
`timescale 1ns/1ps

module exec_alu import exec_pkg::*; (
    input  uop_t     uop,
    output alu_res_t alu_res
);

    // Flag groups per opcode class
    localparam flags_t FM_ARITH = '{cf: 1'b1, pf: 1'b1, af: 1'b1, zf: 1'b1,
                                    sf: 1'b1, of: 1'b1, df: 1'b0};
    localparam flags_t FM_LOGIC = '{cf: 1'b1, pf: 1'b1, af: 1'b0, zf: 1'b1,
                                    sf: 1'b1, of: 1'b1, df: 1'b0};
    localparam flags_t FM_SHIFT = '{cf: 1'b1, pf: 1'b1, af: 1'b0, zf: 1'b1,
                                    sf: 1'b1, of: 1'b0, df: 1'b0};

    logic [SHAMT_W-1:0] shamt;
    logic [XLEN:0]      add_full;  // Carry out in top bit
    logic [XLEN:0]      sub_full;  // Borrow in top bit
    logic [XLEN:0]      sal_full;  // Last bit shifted out lands in top bit
    logic [XLEN:0]      sar_full;  // Last bit shifted out lands in bit 0
    flags_t             fl;
    flags_t             mask;

    assign shamt    = uop.op2[SHAMT_W-1:0];
    assign add_full = {1'b0, uop.op1} + {1'b0, uop.op2};
    assign sub_full = {1'b0, uop.op1} - {1'b0, uop.op2};
    assign sal_full = {1'b0, uop.op1} << shamt;
    assign sar_full = $signed({uop.op1, 1'b0}) >>> shamt;  // Sign bit refills from the top

    always_comb begin
        alu_res       = '0;
        alu_res.dest1 = uop.dest1;
        alu_res.dest2 = uop.dest2;
        alu_res.wb1   = uop.ld1;
        alu_res.wb2   = uop.ld2;
        fl            = '0;
        mask          = '0;

        case (uop.op)
            OP_ADD: begin
                alu_res.res1 = add_full[XLEN-1:0];
                fl.cf        = add_full[XLEN];
                fl.af        = uop.op1[4] ^ uop.op2[4] ^ add_full[4];  // Carry into bit 4
                fl.of        = (uop.op1[XLEN-1] == uop.op2[XLEN-1]) &&
                               (add_full[XLEN-1] != uop.op1[XLEN-1]);
                mask         = FM_ARITH;
            end
            OP_CMP: begin
                alu_res.res1 = sub_full[XLEN-1:0];  // Only feeds the flags
                alu_res.wb1  = 1'b0;
                alu_res.wb2  = 1'b0;
                fl.cf        = sub_full[XLEN];
                fl.af        = uop.op1[4] ^ uop.op2[4] ^ sub_full[4];
                fl.of        = (uop.op1[XLEN-1] != uop.op2[XLEN-1]) &&
                               (sub_full[XLEN-1] != uop.op1[XLEN-1]);
                mask         = FM_ARITH;
            end
            OP_AND: begin
                alu_res.res1 = uop.op1 & uop.op2;
                mask         = FM_LOGIC;  // cf and of stay cleared
            end
            OP_OR: begin
                alu_res.res1 = uop.op1 | uop.op2;
                mask         = FM_LOGIC;
            end
            OP_NOT: begin
                alu_res.res1 = ~uop.op1;  // No flags touched
            end
            OP_SAL: begin
                alu_res.res1 = sal_full[XLEN-1:0];
                fl.cf        = sal_full[XLEN];
                // Overflow defined for single-bit shifts only
                fl.of        = sal_full[XLEN-1] ^ sal_full[XLEN];
                if (shamt != '0) begin
                    mask    = FM_SHIFT;
                    mask.of = (shamt == SHAMT_W'(1));
                end
            end
            OP_SAR: begin
                alu_res.res1 = sar_full[XLEN:1];
                fl.cf        = sar_full[0];
                fl.of        = 1'b0;  // Sign never changes
                if (shamt != '0) begin
                    mask    = FM_SHIFT;
                    mask.of = (shamt == SHAMT_W'(1));
                end
            end
            OP_MOV, OP_CMOVC: begin
                alu_res.res1 = uop.op2;  // CMOVC kill decided at commit
            end
            OP_XCHG: begin
                // Values and destinations cross over
                alu_res.res1  = uop.op2;
                alu_res.res2  = uop.op1;
                alu_res.dest1 = uop.dest2;
                alu_res.dest2 = uop.dest1;
            end
            OP_JMP, OP_JMPF, OP_JCC: begin
                alu_res.wb1 = 1'b0;  // Branch resolver owns jumps
                alu_res.wb2 = 1'b0;
            end
            default: begin
                alu_res.res1 = uop.op1;  // NOP passes op1 along
            end
        endcase

        // Result-based flags shared by every flag-writing op
        fl.pf = ~^alu_res.res1[7:0];  // Even parity of low byte
        fl.zf = (alu_res.res1 == '0);
        fl.sf = alu_res.res1[XLEN-1];

        alu_res.flags = fl;
        alu_res.fmask = mask;
    end

endmodule

/* hdl/exec_branch.sv */
// Branch resolver with condition evaluation and prediction check
`timescale 1ns/1ps

module exec_branch import exec_pkg::*; (
    input  uop_t    uop,
    input  flags_t  flags_q,
    output br_res_t br_res
);

    cond_e           eff_cond;  // Condition actually tested
    logic            cond_met;
    logic            is_br;
    logic            taken;
    logic [XLEN-1:0] target;

    // CMOVC always tests carry, whatever cond says
    assign eff_cond = (uop.op == OP_CMOVC) ? CC_C : uop.cond;

    always_comb begin
        case (eff_cond)
            CC_ALWAYS: cond_met = 1'b1;
            CC_C:      cond_met = flags_q.cf;
            CC_NC:     cond_met = ~flags_q.cf;
            CC_Z:      cond_met = flags_q.zf;
            CC_NZ:     cond_met = ~flags_q.zf;
            default:   cond_met = 1'b0;  // Unused encodings never pass
        endcase
    end

    assign is_br = uop.valid &&
                   (uop.op == OP_JMP || uop.op == OP_JMPF || uop.op == OP_JCC);

    always_comb begin
        taken  = 1'b0;
        target = uop.next_eip + uop.op1;  // Near displacement
        case (uop.op)
            OP_JMP:  taken = 1'b1;
            OP_JCC:  taken = cond_met;
            OP_JMPF: begin
                taken  = 1'b1;
                target = uop.op1;  // Absolute offset in new segment
            end
            default: taken = 1'b0;
        endcase
        taken = taken & is_br;
    end

    always_comb begin
        br_res          = '0;
        br_res.valid    = is_br;
        br_res.taken    = taken;
        br_res.cond_met = cond_met;
        br_res.fip      = taken ? target : uop.next_eip;
        br_res.cs       = (uop.op == OP_JMPF) ? uop.op2[CS_W-1:0] : '0;
        // Direction must match, target only matters when taken
        br_res.correct  = (taken == uop.pred_taken) &&
                          (!taken || target == uop.pred_target);
    end

endmodule

/* hdl/exec_commit.sv */
// Commit block with EFLAGS register, CMOVC kill and registered result and branch bundles
`timescale 1ns/1ps

module exec_commit import exec_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            uop_valid,
    input  alu_op_e         uop_op,
    input  logic [XLEN-1:0] uop_eip,
    input  alu_res_t        alu_res,
    input  br_res_t         br_res,
    output flags_t          flags_q,
    output commit_t         commit,
    output br_res_t         branch
);

    logic              kill;   // CMOVC with carry clear
    logic              live;   // Valid and not killed
    logic [FLAG_W-1:0] wmask;  // Effective flag write enables
    flags_t            flags_d;

    assign kill  = uop_valid && (uop_op == OP_CMOVC) && !br_res.cond_met;
    assign live  = uop_valid && !kill;
    assign wmask = live ? alu_res.fmask : '0;

    // Per-bit merge of new flags into the register
    assign flags_d = flags_t'((flags_q & ~wmask) | (alu_res.flags & wmask));

    always_ff @(posedge clk) begin
        if (rst) begin
            flags_q <= '0;
        end else begin
            flags_q <= flags_d;  // Next op sees this value
        end
    end

    // Result bundle
    always_ff @(posedge clk) begin
        commit.eip   <= uop_eip;
        commit.res1  <= alu_res.res1;
        commit.res2  <= alu_res.res2;
        commit.dest1 <= alu_res.dest1;
        commit.dest2 <= alu_res.dest2;
        if (rst) begin
            commit.valid <= 1'b0;
            commit.wb1   <= 1'b0;
            commit.wb2   <= 1'b0;
        end else begin
            commit.valid <= live;
            commit.wb1   <= live && alu_res.wb1;  // Killed op writes nothing
            commit.wb2   <= live && alu_res.wb2;
        end
    end

    // Branch bundle
    always_ff @(posedge clk) begin
        branch.correct  <= br_res.correct;
        branch.fip      <= br_res.fip;
        branch.cs       <= br_res.cs;
        branch.cond_met <= br_res.cond_met;
        if (rst) begin
            branch.valid <= 1'b0;
            branch.taken <= 1'b0;
        end else begin
            branch.valid <= br_res.valid;  // Already qualified by uop valid
            branch.taken <= br_res.taken;
        end
    end

endmodule

/* hdl/execute_top.sv */
// Execute stage top level with ALU, branch resolver and commit block
`timescale 1ns/1ps

module execute_top import exec_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  uop_t    uop,
    output commit_t commit,
    output br_res_t branch,
    output flags_t  eflags
);

    alu_res_t alu_res;  // Zero-latency ALU result
    br_res_t  br_res;   // Zero-latency branch resolution

    // Both units look at the same micro-op
    exec_alu u_alu (
        .uop     (uop),
        .alu_res (alu_res)
    );

    exec_branch u_branch (
        .uop     (uop),
        .flags_q (eflags),  // Flags left by the previous op
        .br_res  (br_res)
    );

    // One cycle to the outputs
    exec_commit u_commit (
        .clk       (clk),
        .rst       (rst),
        .uop_valid (uop.valid),
        .uop_op    (uop.op),
        .uop_eip   (uop.eip),
        .alu_res   (alu_res),
        .br_res    (br_res),
        .flags_q   (eflags),
        .commit    (commit),
        .branch    (branch)
    );

endmodule

/* test/execute_asserts.sv */
// Bound assertions on reset state, branch and writeback exclusion, and CMOVC kill
`timescale 1ns/1ps

module execute_asserts import exec_pkg::*; (
    input logic    clk,
    input logic    rst,
    input uop_t    uop,
    input commit_t commit,
    input br_res_t branch,
    input flags_t  eflags
);

    // Every reset edge leaves the stage quiet
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !commit.valid && !commit.wb1 && !commit.wb2 &&
                !branch.valid && !branch.taken && eflags == '0)
        else $error("outputs active after a reset edge");

    // Jumps never write a register
    a_branch_no_wb: assert property (@(posedge clk) disable iff (rst)
        !(branch.valid && commit.wb1))
        else $error("branch committed together with a writeback");

    // CMOVC with carry clear is dropped
    a_cmov_kill: assert property (@(posedge clk) disable iff (rst)
        (uop.valid && uop.op == OP_CMOVC && !eflags.cf) |=>
            !commit.valid && !commit.wb1 && !commit.wb2)
        else $error("killed conditional move wrote back");

endmodule

bind execute_top execute_asserts u_asserts (
    .clk    (clk),
    .rst    (rst),
    .uop    (uop),
    .commit (commit),
    .branch (branch),
    .eflags (eflags)
);

/* test/execute_tb.sv */
// Execute stage testbench with clock, reset, stimulus, reference model, checks and reporting
`timescale 1ns/1ps

module execute_tb import exec_pkg::*; ();

    localparam int RST_CYCLES     = 8;
    localparam int TEST_CYCLES    = 12 + 225 + 45 + 12 + 12 + 45;  // Upper bound per test
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 100;

    logic    clk;
    logic    rst;
    uop_t    uop;
    commit_t commit;
    br_res_t branch;
    flags_t  eflags;

    flags_t          mflags;      // Model EFLAGS
    commit_t         exp_commit;  // Expected outputs of the op in flight
    br_res_t         exp_branch;
    flags_t          exp_flags;
    logic            exp_far;     // Selector must match
    logic [XLEN-1:0] pc;
    int              errors;
    int              checks;
    int              test_errs;   // Error count at start of current test
    int              cycles;

    execute_top dut (
        .clk    (clk),
        .rst    (rst),
        .uop    (uop),
        .commit (commit),
        .branch (branch),
        .eflags (eflags)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Simulation timed out after %0d cycles", cycles);
        $display("sim failed");
        $finish;
    end

    function automatic logic cond_ok(input cond_e cc, input flags_t f);
        case (cc)
            CC_ALWAYS: return 1'b1;
            CC_C:      return f.cf;
            CC_NC:     return !f.cf;
            CC_Z:      return f.zf;
            CC_NZ:     return !f.zf;
            default:   return 1'b0;
        endcase
    endfunction

    // Reference model of one micro-op, fills the expectation for the next edge
    task automatic predict(input uop_t u);
        logic [XLEN:0]   wide;
        logic [XLEN:0]   swide;  // Sign-extended result for overflow
        logic [XLEN-1:0] tgt;
        flags_t          nf;
        flags_t          fm;  // Flags this op writes
        int              sh;
        logic            met;
        logic            is_br;
        logic            no_wb;
        nf = '0;
        fm = '0;
        sh = u.op2[4:0];
        exp_commit       = '0;
        exp_commit.eip   = u.eip;
        exp_commit.dest1 = u.dest1;
        exp_commit.dest2 = u.dest2;
        case (u.op)
            OP_ADD: begin
                wide            = {1'b0, u.op1} + {1'b0, u.op2};
                swide           = {u.op1[31], u.op1} + {u.op2[31], u.op2};
                exp_commit.res1 = wide[XLEN-1:0];
                nf.cf = wide[XLEN];
                nf.af = ({1'b0, u.op1[3:0]} + {1'b0, u.op2[3:0]}) > 5'd15;  // Nibble carry
                nf.of = swide[XLEN] != swide[XLEN-1];  // Signed sum leaves 32 bits
                fm    = 7'b1111110;  // All but df
            end
            OP_CMP: begin
                exp_commit.res1 = u.op1 - u.op2;
                swide = {u.op1[31], u.op1} - {u.op2[31], u.op2};
                nf.cf = u.op1 < u.op2;  // Borrow
                nf.af = u.op1[3:0] < u.op2[3:0];
                nf.of = swide[XLEN] != swide[XLEN-1];
                fm    = 7'b1111110;
            end
            OP_AND, OP_OR: begin
                exp_commit.res1 = (u.op == OP_AND) ? (u.op1 & u.op2) : (u.op1 | u.op2);
                fm = 7'b1101110;  // cf and of cleared, af kept
            end
            OP_NOT: exp_commit.res1 = ~u.op1;
            OP_SAL: begin
                exp_commit.res1 = u.op1 << sh;
                nf.cf = (sh != 0) && u.op1[XLEN-sh];  // Last bit out on the left
                nf.of = exp_commit.res1[31] ^ nf.cf;
            end
            OP_SAR: begin
                exp_commit.res1 = $signed(u.op1) >>> sh;
                nf.cf = (sh != 0) && u.op1[sh-1];
            end
            OP_MOV, OP_CMOVC: exp_commit.res1 = u.op2;
            OP_XCHG: begin
                exp_commit.res1  = u.op2;
                exp_commit.res2  = u.op1;
                exp_commit.dest1 = u.dest2;  // Registers swap
                exp_commit.dest2 = u.dest1;
            end
            default: ;
        endcase
        if ((u.op == OP_SAL || u.op == OP_SAR) && sh != 0) begin
            fm = (sh == 1) ? 7'b1101110 : 7'b1101100;  // of only on a single-bit shift
        end
        nf.pf = ~^exp_commit.res1[7:0];
        nf.zf = (exp_commit.res1 == '0);
        nf.sf = exp_commit.res1[31];
        met   = cond_ok((u.op == OP_CMOVC) ? CC_C : u.cond, mflags);
        is_br = u.valid && (u.op inside {OP_JMP, OP_JMPF, OP_JCC});
        no_wb = u.op inside {OP_CMP, OP_JMP, OP_JMPF, OP_JCC};
        exp_commit.valid = u.valid && !(u.op == OP_CMOVC && !met);  // CMOVC kill
        exp_commit.wb1   = exp_commit.valid && u.ld1 && !no_wb;
        exp_commit.wb2   = exp_commit.valid && u.ld2 && !no_wb;
        tgt = (u.op == OP_JMPF) ? u.op1 : u.next_eip + u.op1;
        exp_branch          = '0;
        exp_branch.valid    = is_br;
        exp_branch.taken    = is_br && (u.op != OP_JCC || met);
        exp_branch.fip      = exp_branch.taken ? tgt : u.next_eip;
        exp_branch.cs       = u.op2[15:0];
        exp_branch.cond_met = met;
        exp_branch.correct  = (exp_branch.taken == u.pred_taken) &&
                              (!exp_branch.taken || tgt == u.pred_target);
        exp_far = is_br && (u.op == OP_JMPF);
        if (exp_commit.valid) begin
            mflags = flags_t'((mflags & ~fm) | (nf & fm));
        end
        exp_flags = mflags;
    endtask

    task automatic compare_field(input string name, input logic [XLEN-1:0] exp,
                                 input logic [XLEN-1:0] got);
        checks++;
        assert (got === exp) else begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_outputs();
        compare_field("commit.valid", exp_commit.valid, commit.valid);
        compare_field("commit.wb1", exp_commit.wb1, commit.wb1);
        compare_field("commit.wb2", exp_commit.wb2, commit.wb2);
        compare_field("branch.valid", exp_branch.valid, branch.valid);
        compare_field("branch.taken", exp_branch.taken, branch.taken);
        compare_field("eflags", XLEN'(exp_flags), XLEN'(eflags));
        if (exp_commit.valid) compare_field("commit.eip", exp_commit.eip, commit.eip);
        if (exp_commit.wb1) begin
            compare_field("commit.res1", exp_commit.res1, commit.res1);
            compare_field("commit.dest1", exp_commit.dest1, commit.dest1);
        end
        if (exp_commit.wb2) begin
            compare_field("commit.res2", exp_commit.res2, commit.res2);
            compare_field("commit.dest2", exp_commit.dest2, commit.dest2);
        end
        if (exp_branch.valid) begin
            compare_field("branch.correct", exp_branch.correct, branch.correct);
            compare_field("branch.fip", exp_branch.fip, branch.fip);
            compare_field("branch.cond_met", exp_branch.cond_met, branch.cond_met);
        end
        if (exp_far) compare_field("branch.cs", exp_branch.cs, branch.cs);
    endtask

    // Check previous op on the falling edge, then drive the next one
    task automatic issue(input uop_t u);
        @(negedge clk);
        check_outputs();
        predict(u);
        uop = u;
        pc  = pc + 4;
    endtask

    function automatic uop_t make_uop(input alu_op_e op, input logic [XLEN-1:0] op1,
                                      input logic [XLEN-1:0] op2);
        uop_t u;
        u          = '0;
        u.valid    = 1'b1;
        u.op       = op;
        u.cond     = CC_ALWAYS;
        u.eip      = pc;
        u.next_eip = pc + 4;
        u.op1      = op1;
        u.op2      = op2;
        u.dest1    = $urandom_range(7);  // Register number
        u.dest2    = $urandom_range(7);
        u.ld1      = 1'b1;
        u.ld2      = (op == OP_XCHG);
        return u;
    endfunction

    task automatic jump(input alu_op_e op, input cond_e cc, input logic [XLEN-1:0] op1,
                        input logic [XLEN-1:0] op2, input logic pred, input logic bad_tgt);
        uop_t            u;
        logic [XLEN-1:0] tgt;
        u    = make_uop(op, op1, op2);  // ld1 stays set, DUT must drop it
        u.cond = cc;
        tgt  = (op == OP_JMPF) ? op1 : u.next_eip + op1;
        u.pred_taken  = pred;
        u.pred_target = bad_tgt ? tgt ^ 32'h0000_0010 : tgt;
        issue(u);
    endtask

    task automatic finish_test(input string name);
        issue('0);  // Flush last op into the check
        $display("test %-7s done, %0d errors", name, errors - test_errs);
        test_errs = errors;
    endtask

    task automatic arith_ops();
        alu_op_e ops[5] = '{OP_ADD, OP_AND, OP_OR, OP_NOT, OP_CMP};
        issue(make_uop(OP_ADD, 32'hffff_ffff, 32'h0000_0001));  // Carry, zero, adjust
        issue(make_uop(OP_ADD, 32'h7fff_ffff, 32'h0000_0001));  // Signed overflow
        issue(make_uop(OP_ADD, 32'h0000_0001, 32'h0000_0002));  // Even parity
        issue(make_uop(OP_ADD, 32'h0000_0001, 32'h0000_0000));  // Odd parity
        issue(make_uop(OP_AND, 32'hf0f0_f0f0, 32'h0f0f_0f0f));
        issue(make_uop(OP_OR, 32'h8000_0000, 32'h0000_0001));
        issue(make_uop(OP_NOT, 32'h0000_0000, 32'h1234_5678));
        issue(make_uop(OP_CMP, 32'h0000_0005, 32'h0000_0005));
        issue(make_uop(OP_CMP, 32'h0000_0000, 32'h0000_0001));  // Borrow
        issue(make_uop(OP_CMP, 32'h8000_0000, 32'h0000_0001));  // Overflow
        repeat (200) issue(make_uop(ops[$urandom_range(4)], $urandom(), $urandom()));
        finish_test("arith");
    endtask

    task automatic shift_ops();
        int cnt[3] = '{0, 1, 31};
        issue(make_uop(OP_ADD, 32'hffff_ffff, 32'h0000_0001));  // Nonzero flags first
        foreach (cnt[i]) begin
            // Upper count bits must be ignored
            issue(make_uop(OP_SAL, 32'hc000_0001, ($urandom() & 32'hffff_ffe0) | cnt[i]));
            issue(make_uop(OP_SAR, 32'h8000_0003, ($urandom() & 32'hffff_ffe0) | cnt[i]));
            issue(make_uop(OP_SAL, 32'h4000_0002, cnt[i]));
            issue(make_uop(OP_SAR, 32'h7fff_fffe, cnt[i]));
        end
        repeat (20) issue(make_uop($urandom_range(1) ? OP_SAL : OP_SAR, $urandom(), $urandom()));
        finish_test("shift");
    endtask

    task automatic move_ops();
        issue(make_uop(OP_ADD, 32'h7fff_ffff, 32'h0000_0001));
        issue(make_uop(OP_MOV, 32'h0000_0000, 32'hcafe_0001));
        issue(make_uop(OP_XCHG, 32'h1111_2222, 32'h3333_4444));
        issue(make_uop(OP_XCHG, $urandom(), $urandom()));
        issue(make_uop(OP_MOV, $urandom(), 32'h0000_0000));
        finish_test("move");
    endtask

    task automatic cmov_ops();
        issue(make_uop(OP_ADD, 32'hffff_ffff, 32'h0000_0002));  // cf set
        issue(make_uop(OP_CMOVC, 32'h0, 32'h0bad_f00d));
        issue(make_uop(OP_ADD, 32'h0000_0001, 32'h0000_0001));  // cf clear
        issue(make_uop(OP_CMOVC, 32'h0, 32'h0000_1234));        // Killed
        issue(make_uop(OP_CMP, 32'h0000_0000, 32'h0000_0001));  // cf set by borrow
        issue(make_uop(OP_CMOVC, 32'h0, 32'h5555_aaaa));
        finish_test("cmov");
    endtask

    task automatic branch_ops();
        jump(OP_JMP, CC_ALWAYS, 32'h0000_0100, '0, 1'b1, 1'b0);
        jump(OP_JMP, CC_ALWAYS, 32'hffff_fff0, '0, 1'b0, 1'b0);  // Direction missed
        jump(OP_JMP, CC_ALWAYS, 32'h0000_0040, '0, 1'b1, 1'b1);  // Target missed
        jump(OP_JMPF, CC_ALWAYS, 32'h0001_2000, 32'h0000_0008, 1'b1, 1'b0);
        jump(OP_JMPF, CC_ALWAYS, 32'h0000_4000, 32'hdead_001b, 1'b1, 1'b1);
        for (int s = 0; s < 2; s++) begin
            // cf and zf both set, then both clear
            issue(make_uop(OP_ADD, s ? 32'h0000_0001 : 32'hffff_ffff, 32'h0000_0001));
            for (int c = 0; c < 5; c++) begin
                jump(OP_JCC, cond_e'(c), $urandom(), '0, 1'b1, 1'b0);
                jump(OP_JCC, cond_e'(c), $urandom(), '0, 1'b0, 1'b0);
                jump(OP_JCC, cond_e'(c), $urandom(), '0, 1'b1, 1'b1);
            end
        end
        finish_test("branch");
    endtask

    initial begin
        void'($urandom(32'h3719084c));
        rst        = 1'b1;
        uop        = '0;
        mflags     = '0;
        exp_commit = '0;  // Reset state expected
        exp_branch = '0;
        exp_flags  = '0;
        exp_far    = 1'b0;
        pc         = 32'h0000_1000;
        errors     = 0;
        checks     = 0;
        test_errs  = 0;
        repeat (RST_CYCLES) begin
            @(negedge clk);
            check_outputs();
        end
        rst = 1'b0;
        issue('0);
        finish_test("reset");
        arith_ops();
        shift_ops();
        move_ops();
        cmov_ops();
        branch_ops();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* execute_top.f */
hdl/exec_pkg.sv
hdl/exec_alu.sv
hdl/exec_branch.sv
hdl/exec_commit.sv
hdl/execute_top.sv
test/execute_asserts.sv
test/execute_tb.sv
